// File: filelist.f
+incdir+verilog
verilog/modmul_pkg.sv
verilog/grid_mult.sv
verilog/mod_reduce_lut.sv
verilog/mod_final_sub.sv
verilog/modmul_top.sv
sim/modmul_tb.sv

// File: sim/modmul_tb.sv
`timescale 1ns/100ps
// Testbench for the pipelined modular multiplier.
// Directed table, latency probe, random streams and random back-pressure.
module modmul_tb;

  localparam int NUM_DIR    = 10;                        // Directed table entries.
  localparam int WAIT_LIMIT = 2000;                      // Cycles before a wait gives up.

  logic              i_clk;
  logic              i_rst;
  logic              i_val;
  logic              i_rdy;
  modmul_pkg::oper_t i_dat_a;
  modmul_pkg::oper_t i_dat_b;
  logic              o_val;
  logic              o_rdy;
  modmul_pkg::oper_t o_dat;

  modmul_pkg::oper_t dir_a   [NUM_DIR];                  // Directed operand A.
  modmul_pkg::oper_t dir_b   [NUM_DIR];                  // Directed operand B.
  modmul_pkg::oper_t dir_exp [NUM_DIR];                  // Expected residue.
  modmul_pkg::oper_t exp_q [$];                          // Scoreboard in acceptance order.

  int  err_cnt     = 0;
  int  chk_cnt     = 0;
  int  test_cnt    = 0;
  bit  gap_chk     = 1'b0;                               // Outputs must come every cycle.
  int  burst_outs  = 0;
  time last_out_t  = 0;
  bit  prev_stall  = 1'b0;
  logic              prev_val = 1'b0;
  modmul_pkg::oper_t prev_dat = '0;

  modmul_top dut (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_val   (i_val),
    .i_rdy   (i_rdy),
    .i_dat_a (i_dat_a),
    .i_dat_b (i_dat_b),
    .o_val   (o_val),
    .o_rdy   (o_rdy),
    .o_dat   (o_dat)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;                           // 10 ns period.
  end

  // Reference residue straight from the 108-bit product.
  function automatic modmul_pkg::oper_t mod_product(
    input modmul_pkg::oper_t a,
    input modmul_pkg::oper_t b
  );
    modmul_pkg::prod_t p;
    modmul_pkg::prod_t m;
    p = modmul_pkg::prod_t'(a) * modmul_pkg::prod_t'(b);
    m = modmul_pkg::prod_t'(modmul_pkg::MODULUS);
    return modmul_pkg::oper_t'(p % m);
  endfunction

  function automatic modmul_pkg::oper_t rand_oper();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return modmul_pkg::oper_t'(r % modmul_pkg::MODULUS); // Always below the modulus.
  endfunction

  task automatic check_result(input modmul_pkg::oper_t got, input modmul_pkg::oper_t exp,
                              input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("[ERROR] %0t %s: got %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting: %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    $display("test %0d %s: %s, %0d errors", test_cnt, name,
             (err_cnt == err_before) ? "ok" : "failed", err_cnt - err_before);
  endtask

  // Output monitor sampled on the rising edge.
  always @(posedge i_clk) begin
    if (!i_rst) begin
      check_bit(o_rdy, i_rdy, "o_rdy follows i_rdy");
      if (prev_stall) begin                              // Pipeline was frozen.
        check_bit(o_val, prev_val, "o_val held under stall");
        if (prev_val) begin
          check_result(o_dat, prev_dat, "o_dat held under stall");
        end
      end
      if (o_val && i_rdy) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Output at %0t with no input waiting for it", $time);
        end else begin
          check_result(o_dat, exp_q.pop_front(), "result");
        end
        if (gap_chk && burst_outs > 0) begin
          check_cycles(int'(($time - last_out_t) / 10), 1, "output spacing");
        end
        burst_outs++;
        last_out_t = $time;
      end
      prev_stall = !i_rdy;
      prev_val   = o_val;
      prev_dat   = o_dat;
    end
  end

  // Holds one pair until the DUT takes it.
  task automatic send_pair(input modmul_pkg::oper_t a, input modmul_pkg::oper_t b,
                           input modmul_pkg::oper_t exp);
    int guard;
    guard = 0;
    @(negedge i_clk);
    i_val   = 1'b1;
    i_dat_a = a;
    i_dat_b = b;
    @(posedge i_clk);
    while (!o_rdy) begin
      guard++;
      if (guard > WAIT_LIMIT) stop_on_timeout("pair never accepted");
      @(posedge i_clk);
    end
    exp_q.push_back(exp);
  endtask

  // Random pairs with random bubbles and stalls when bp is set.
  task automatic run_stream(input int n, input bit bp);
    int                sent;
    int                guard;
    logic              vld;
    modmul_pkg::oper_t a;
    modmul_pkg::oper_t b;
    sent  = 0;
    guard = 0;
    a     = rand_oper();
    b     = rand_oper();
    while (sent < n) begin
      @(negedge i_clk);
      i_rdy   = bp ? ($urandom() % 3 != 0) : 1'b1;
      vld     = bp ? ($urandom() % 4 != 0) : 1'b1;
      i_val   = vld;
      i_dat_a = a;
      i_dat_b = b;
      @(posedge i_clk);
      if (o_rdy && vld) begin
        exp_q.push_back(mod_product(a, b));
        sent++;
        guard = 0;
        a     = rand_oper();                             // Next pair only after a transfer.
        b     = rand_oper();
      end else begin
        guard++;
        if (guard > WAIT_LIMIT) stop_on_timeout("stream stalled");
      end
    end
  endtask

  task automatic wait_drain();
    int guard;
    guard = 0;
    @(negedge i_clk);
    i_val = 1'b0;
    i_rdy = 1'b1;
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
      guard++;
      if (guard > WAIT_LIMIT) stop_on_timeout("pipeline drain");
    end
  endtask

  task automatic fill_table();
    modmul_pkg::oper_t m1;
    m1 = modmul_pkg::MODULUS - 1;
    dir_a[0] = '0;                                       // Zero times anything.
    dir_b[0] = m1;
    dir_a[1] = m1;
    dir_b[1] = '0;
    dir_a[2] = 54'd1;
    dir_b[2] = 54'h1234_5678_9ABCD;
    dir_a[3] = m1;
    dir_b[3] = 54'd1;
    dir_a[4] = m1;                                       // Largest product.
    dir_b[4] = m1;
    dir_a[5] = m1;
    dir_b[5] = m1 - 1;
    dir_a[6] = m1 - 1;
    dir_b[6] = m1 - 2;
    dir_a[7] = 54'd1 << 53;
    dir_b[7] = 54'd1 << 53;
    dir_a[8] = (54'd1 << 53) - 1;
    dir_b[8] = (54'd1 << 53) - 1;
    dir_a[9] = 54'h2A_AAAA_AAAA_AAAA;
    dir_b[9] = 54'h15_5555_5555_5555;
    for (int i = 0; i < NUM_DIR; i++) begin
      dir_exp[i] = mod_product(dir_a[i], dir_b[i]);
    end
  endtask

  initial begin
    int e0;
    int cnt;
    void'($urandom(73686));
    i_rst   = 1'b1;
    i_val   = 1'b0;
    i_rdy   = 1'b1;
    i_dat_a = '0;
    i_dat_b = '0;
    fill_table();
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    e0 = err_cnt;
    repeat (20) begin
      @(posedge i_clk);
      check_bit(o_val, 1'b0, "o_val idle after reset");
    end
    report_test("idle after reset", e0);

    e0 = err_cnt;
    for (int i = 0; i < NUM_DIR; i++) begin
      send_pair(dir_a[i], dir_b[i], dir_exp[i]);
    end
    wait_drain();
    report_test("directed table", e0);

    e0 = err_cnt;
    send_pair(54'h0F_EDCB_A987_6543, 54'h21_0123_4567_89AB,
              mod_product(54'h0F_EDCB_A987_6543, 54'h21_0123_4567_89AB));
    @(negedge i_clk);
    i_val = 1'b0;
    cnt   = 1;
    @(posedge i_clk);
    while (!o_val) begin
      cnt++;
      if (cnt > WAIT_LIMIT) stop_on_timeout("single result");
      @(posedge i_clk);
    end
    check_cycles(cnt, 7, "latency");
    wait_drain();
    report_test("single pair latency", e0);

    e0 = err_cnt;
    gap_chk    = 1'b1;
    burst_outs = 0;
    run_stream(200, 1'b0);
    wait_drain();
    gap_chk = 1'b0;
    check_cycles(burst_outs, 200, "results in burst");
    report_test("back-to-back stream", e0);

    e0 = err_cnt;
    run_stream(300, 1'b1);
    wait_drain();
    report_test("back-pressure stream", e0);

    repeat (10) @(posedge i_clk);
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0 && exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/modmul_top.sv
`timescale 1ns/100ps
// Pipelined modular multiplier, seven enabled cycles from input to result.
// Multiply, table fold and final subtraction share one downstream ready.
module modmul_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_val,
  input  logic              i_rdy,
  input  modmul_pkg::oper_t i_dat_a,
  input  modmul_pkg::oper_t i_dat_b,
  output logic              o_val,
  output logic              o_rdy,
  output modmul_pkg::oper_t o_dat
);

  logic              gm_val;                             // Product valid.
  modmul_pkg::prod_t gm_prod;                            // Full product.
  logic              rl_val;                             // Fold valid.
  modmul_pkg::red_t  rl_fold;                            // Folded sum.

  // Ready comes back from the multiplier stage.
  grid_mult u_grid_mult (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_val   (i_val),
    .i_rdy   (i_rdy),
    .i_dat_a (i_dat_a),
    .i_dat_b (i_dat_b),
    .o_val   (gm_val),
    .o_rdy   (o_rdy),
    .o_dat   (gm_prod)
  );

  mod_reduce_lut u_mod_reduce_lut (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_val  (gm_val),
    .i_rdy  (i_rdy),                                     // Same ready on every stage.
    .i_prod (gm_prod),
    .o_val  (rl_val),
    .o_rdy  (),
    .o_dat  (rl_fold)
  );

  mod_final_sub u_mod_final_sub (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (rl_val),
    .i_rdy (i_rdy),
    .i_dat (rl_fold),
    .o_val (o_val),
    .o_rdy (),
    .o_dat (o_dat)
  );

endmodule

// File: verilog/mod_final_sub.sv
`timescale 1ns/100ps
// Final reduction, subtracts the largest multiple of the modulus.
module mod_final_sub (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_val,
  input  logic              i_rdy,
  input  modmul_pkg::red_t  i_dat,
  output logic              o_val,
  output logic              o_rdy,
  output modmul_pkg::oper_t o_dat
);

  modmul_pkg::red_t fold_mul [modmul_pkg::MAX_FOLD+1];   // 0 to 7 times the modulus.
  logic [modmul_pkg::MAX_FOLD:1] ge;                      // Sum reaches multiple k.
  modmul_pkg::red_t sel_mul;
  modmul_pkg::red_t diff;
  logic             val_q;

  assign o_rdy = i_rdy;
  assign o_val = val_q;

  // Constant multiples, folded away by synthesis.
  always_comb begin
    fold_mul[0] = '0;
    for (int k = 1; k <= modmul_pkg::MAX_FOLD; k++) begin
      fold_mul[k] = fold_mul[k-1]
                    + {{(modmul_pkg::RED_W-modmul_pkg::OPER_W){1'b0}}, modmul_pkg::MODULUS};
    end
  end

  // Parallel compares, then pick the highest one that holds.
  always_comb begin
    for (int k = 1; k <= modmul_pkg::MAX_FOLD; k++) begin
      ge[k] = (i_dat >= fold_mul[k]);
    end
    sel_mul = fold_mul[0];
    for (int k = 1; k <= modmul_pkg::MAX_FOLD; k++) begin
      if (ge[k]) begin
        sel_mul = fold_mul[k];                           // Later k wins.
      end
    end
    diff = i_dat - sel_mul;                              // Below the modulus.
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= 1'b0;
    end else if (i_rdy) begin
      val_q <= i_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      o_dat <= diff[modmul_pkg::OPER_W-1:0];             // Upper bits are zero here.
    end
  end

endmodule

// File: verilog/mod_reduce_lut.sv
`timescale 1ns/100ps
// Table-based fold of a 108-bit product into a 57-bit congruent sum.
// Upper half chunks look up their residues, then add onto the lower half.
module mod_reduce_lut (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_val,
  input  logic              i_rdy,
  input  modmul_pkg::prod_t i_prod,
  output logic              o_val,
  output logic              o_rdy,
  output modmul_pkg::red_t  o_dat
);

  logic [1:0] val_sr;                                    // Table read, fold.

  // One ROM per upper-half chunk.
  modmul_pkg::oper_t tbl [modmul_pkg::NUM_CHUNK][modmul_pkg::CHUNK_DEPTH];

  modmul_pkg::chunk_t idx   [modmul_pkg::NUM_CHUNK];     // Table addresses.
  modmul_pkg::oper_t  res_q [modmul_pkg::NUM_CHUNK];     // Residues read out.
  modmul_pkg::oper_t  lo_q;                              // Lower product half.
  modmul_pkg::red_t   fold_c;
  modmul_pkg::red_t   ext;

  // Fill the tables from the residue function.
  initial begin
    for (int c = 0; c < modmul_pkg::NUM_CHUNK; c++) begin
      for (int i = 0; i < modmul_pkg::CHUNK_DEPTH; i++) begin
        tbl[c][i] = modmul_pkg::residue_entry(modmul_pkg::chunk_t'(i), c);
      end
    end
  end

  assign o_rdy = i_rdy;
  assign o_val = val_sr[1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_sr <= '0;
    end else if (i_rdy) begin
      val_sr <= {val_sr[0], i_val};
    end
  end

  // Slice the upper half into 9-bit chunks.
  always_comb begin
    for (int c = 0; c < modmul_pkg::NUM_CHUNK; c++) begin
      idx[c] = i_prod[modmul_pkg::OPER_W + c*modmul_pkg::GRID_BIT +: modmul_pkg::GRID_BIT];
    end
  end

  // Cycle 1, table read with the lower half alongside.
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      for (int c = 0; c < modmul_pkg::NUM_CHUNK; c++) begin
        res_q[c] <= tbl[c][idx[c]];                      // Registered ROM read.
      end
      lo_q <= i_prod[modmul_pkg::OPER_W-1:0];
    end
  end

  // Lower half plus six residues, each below the modulus.
  // The total stays below 8 times the modulus.
  always_comb begin
    fold_c = {{(modmul_pkg::RED_W-modmul_pkg::OPER_W){1'b0}}, lo_q};
    ext    = '0;
    for (int c = 0; c < modmul_pkg::NUM_CHUNK; c++) begin
      ext    = {{(modmul_pkg::RED_W-modmul_pkg::OPER_W){1'b0}}, res_q[c]};
      fold_c = fold_c + ext;
    end
  end

  // Cycle 2, folding sum register.
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      o_dat <= fold_c;
    end
  end

endmodule

// File: verilog/grid_mult.sv
`timescale 1ns/100ps
// DSP grid multiplier, 54x54 bits into a 108-bit product.
// Four pipeline stages: capture, DSP products, column sums, product.
module grid_mult (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_val,
  input  logic              i_rdy,
  input  modmul_pkg::oper_t i_dat_a,
  input  modmul_pkg::oper_t i_dat_b,
  output logic              o_val,
  output logic              o_rdy,
  output modmul_pkg::prod_t o_dat
);

  logic [3:0] val_sr;                                    // One bit per stage.

  logic [modmul_pkg::NUM_COL-1:0][modmul_pkg::A_DSP_W-1:0] dat_a;   // A by DSP column.
  logic [modmul_pkg::NUM_ROW-1:0][modmul_pkg::B_DSP_W-1:0] dat_b;   // B by DSP row.

  logic [modmul_pkg::NUM_COL-1:0][modmul_pkg::NUM_ROW-1:0]
        [modmul_pkg::DSP_P_W-1:0]                          mul_grid;  // Registered products.

  logic [modmul_pkg::NUM_COEF-1:0][modmul_pkg::COEF_W-1:0] col_q;     // Column sums.

  modmul_pkg::prod_t prod_c;                             // Recombined product.
  modmul_pkg::prod_t term;                               // One column, zero extended.

  `include "accum_gen.svh"

  assign o_rdy = i_rdy;                                  // No buffering, ready passes back.
  assign o_val = val_sr[3];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_sr <= '0;
    end else if (i_rdy) begin
      val_sr <= {val_sr[2:0], i_val};                    // Advance with the data.
    end
  end

  // Stage 1, operand capture.
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      dat_a <= i_dat_a;
      dat_b <= i_dat_b;
    end
  end

  // Stage 2, one 27x18 product per DSP.
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      for (int gx = 0; gx < modmul_pkg::NUM_COL; gx++) begin
        for (int gy = 0; gy < modmul_pkg::NUM_ROW; gy++) begin
          mul_grid[gx][gy] <= dat_a[gx] * dat_b[gy];     // Maps to a DSP multiplier.
        end
      end
    end
  end

  // Stage 3, sum the grid column by column.
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      col_q <= accum_cols(mul_grid);
    end
  end

  // Weighted column sums, overlapping carries add up here.
  always_comb begin
    prod_c = '0;
    term   = '0;
    for (int i = 0; i < modmul_pkg::NUM_COEF; i++) begin
      term                               = '0;
      term[modmul_pkg::COEF_W-1:0]       = col_q[i];
      prod_c = prod_c + (term << (i*modmul_pkg::GRID_BIT));   // Column weight 2^(9i).
    end
  end

  // Stage 4, product register.
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      o_dat <= prod_c;
    end
  end

endmodule

// File: verilog/modmul_pkg.sv
// Modular multiplier shared definitions.
// Fixed widths, the modulus, vector types and the residue table generator.
package modmul_pkg;

  localparam int OPER_W      = 54;                      // Operand and result width.
  localparam int PROD_W      = 2*OPER_W;                // Full product width.
  localparam int A_DSP_W     = 27;                      // DSP A input width.
  localparam int B_DSP_W     = 18;                      // DSP B input width.
  localparam int DSP_P_W     = A_DSP_W + B_DSP_W;       // One DSP product.
  localparam int GRID_BIT    = 9;                       // Coefficient column width.
  localparam int NUM_COL     = OPER_W / A_DSP_W;        // Operand A splits into 2.
  localparam int NUM_ROW     = OPER_W / B_DSP_W;        // Operand B splits into 3.
  localparam int NUM_COEF    = PROD_W / GRID_BIT;       // 12 columns over the product.
  localparam int COEF_W      = GRID_BIT + 3;            // Room for 6 summed parts.
  localparam int NUM_CHUNK   = OPER_W / GRID_BIT;       // Chunks in the upper half.
  localparam int CHUNK_DEPTH = 1 << GRID_BIT;           // Entries per residue table.
  localparam int RED_W       = OPER_W + 3;              // Lower half plus six residues.
  localparam int MAX_FOLD    = 7;                       // Folded sum stays below 8x modulus.

  typedef logic [OPER_W-1:0]   oper_t;                  // Operand or result.
  typedef logic [PROD_W-1:0]   prod_t;                  // Full product.
  typedef logic [RED_W-1:0]    red_t;                   // Partially reduced sum.
  typedef logic [GRID_BIT-1:0] chunk_t;                 // Table index.

  // Top bit set, so 2^54 < 2*MODULUS and the fold fits below 8*MODULUS.
  localparam oper_t MODULUS = 54'h2E_4B5A_D3C1_7F2B;   // Odd modulus.

  // Value of a chunk at its place in the upper half, reduced.
  // Weight of chunk pos is 2^(OPER_W + pos*GRID_BIT).
  function automatic oper_t residue_entry(
    input chunk_t      idx,
    input int unsigned pos
  );
    logic [OPER_W:0] acc;                                // Spare bit for the doubling.
    logic [OPER_W:0] modv;
    int unsigned     shift;
    modv  = {1'b0, MODULUS};
    acc   = '0;
    acc[GRID_BIT-1:0] = idx;                             // Already below the modulus.
    shift = OPER_W + pos*GRID_BIT;
    for (int unsigned s = 0; s < shift; s++) begin
      acc = acc << 1;                                    // Double.
      if (acc >= modv) begin
        acc = acc - modv;                                // Keep below modulus.
      end
    end
    return acc[OPER_W-1:0];
  endfunction

endpackage

// File: verilog/accum_gen.svh
// Column accumulator for the DSP product grid.
// Spreads each DSP product over 9-bit coefficient columns and sums them.
`ifndef ACCUM_GEN_SVH
`define ACCUM_GEN_SVH

// Each product at column gx, row gy sits at bit 27*gx + 18*gy,
// which is always a multiple of GRID_BIT.
function automatic logic [modmul_pkg::NUM_COEF-1:0][modmul_pkg::COEF_W-1:0] accum_cols(
  input logic [modmul_pkg::NUM_COL-1:0][modmul_pkg::NUM_ROW-1:0]
              [modmul_pkg::DSP_P_W-1:0] grid
);
  logic [modmul_pkg::NUM_COEF-1:0][modmul_pkg::COEF_W-1:0] sums;
  logic [modmul_pkg::COEF_W-1:0]                            part;
  int unsigned                                              base;
  sums = '0;
  for (int gx = 0; gx < modmul_pkg::NUM_COL; gx++) begin
    for (int gy = 0; gy < modmul_pkg::NUM_ROW; gy++) begin
      base = (gx*modmul_pkg::A_DSP_W + gy*modmul_pkg::B_DSP_W)
             / modmul_pkg::GRID_BIT;                     // First column of this product.
      for (int j = 0; j < modmul_pkg::DSP_P_W/modmul_pkg::GRID_BIT; j++) begin
        part = {{(modmul_pkg::COEF_W-modmul_pkg::GRID_BIT){1'b0}},
                grid[gx][gy][j*modmul_pkg::GRID_BIT +: modmul_pkg::GRID_BIT]};
        sums[base+j] = sums[base+j] + part;              // Carries resolve later.
      end
    end
  end
  return sums;
endfunction

`endif
